// File: design/ooo_types_pkg.sv
package ooo_types_pkg;

	// Reorder-buffer tag
	localparam int tag_width = 4;

	typedef logic [tag_width-1:0] tag_t;

	// Source operand whose data is valid once ready is set
	typedef struct packed {
		logic ready;
		tag_t tag;          // Producer to wait for
		logic [31:0] data;
	} operand_t;

	// One beat of the integer result broadcast
	typedef struct packed {
		logic valid;        // Single-cycle strobe
		tag_t tag;
		logic [31:0] data;
	} cdb_t;

endpackage

// File: design/fp_format_pkg.sv
package fp_format_pkg;

	// IEEE 754 single precision
	localparam int fp32_exp_bias = 127;

	typedef struct packed {
		logic sign;
		logic [7:0] exponent;
		logic [22:0] mantissa;  // Hidden bit not stored
	} fp32_fields_t;

	// Same word seen raw or split into fields
	typedef union packed {
		logic [31:0] raw;
		fp32_fields_t fields;
	} fp32_word_u;

endpackage

// File: design/itof_issue_if.sv
`timescale 1ns/10ps

interface itof_issue_if
	import ooo_types_pkg::*;
();
	logic valid;
	tag_t tag;          // Destination
	operand_t operand;
	logic ready;

	modport station (
		input valid,
		input tag,
		input operand,
		output ready
	);

	modport source (
		output valid,
		output tag,
		output operand,
		input ready
	);
endinterface

// File: design/itof_dispatch_if.sv
`timescale 1ns/10ps

interface itof_dispatch_if
	import ooo_types_pkg::*;
();
	logic valid;
	tag_t tag;
	logic [31:0] data;  // Integer operand
	logic ready;

	modport station (
		output valid,
		output tag,
		output data,
		input ready
	);

	modport converter (
		input valid,
		input tag,
		input data,
		output ready
	);
endinterface

// File: design/itof_station.sv
`timescale 1ns/10ps

module itof_station
	import ooo_types_pkg::*;
#(
	parameter int n_entry = 2
) (
	input logic clk,
	input logic reset,
	itof_issue_if.station issue,
	input cdb_t gpr_cdb,
	itof_dispatch_if.station dispatch
);
	localparam int idx_w = (n_entry > 1) ? $clog2(n_entry) : 1;
	localparam int cnt_w = $clog2(n_entry + 1);

	typedef struct packed {
		logic valid;
		tag_t tag;
		operand_t opd;
	} entry_t;

	entry_t e[n_entry];  // Packed toward 0 with the oldest first
	entry_t e_upd[n_entry];
	entry_t e_next[n_entry];
	entry_t e_new;
	logic [idx_w-1:0] sel;
	logic any_ready;
	logic fire;
	logic accept;
	logic [cnt_w-1:0] n_valid;
	logic [cnt_w-1:0] n_keep;

	function automatic operand_t wake(operand_t opd, cdb_t cdb);
		operand_t res;
		res = opd;
		if (!opd.ready && cdb.valid && cdb.tag == opd.tag) begin
			res.ready = 1'b1;
			res.data = cdb.data;
		end
		return res;
	endfunction

	// ----------------------------------------------------------
	// Wakeup of held entries and the incoming one
	// ----------------------------------------------------------
	always_comb begin
		for (int i = 0; i < n_entry; i++) begin
			e_upd[i] = e[i];
			e_upd[i].opd = wake(e[i].opd, gpr_cdb);
		end
		e_new.valid = issue.valid;
		e_new.tag = issue.tag;
		e_new.opd = wake(issue.operand, gpr_cdb);
	end

	// ----------------------------------------------------------
	// Oldest ready entry wins
	// ----------------------------------------------------------
	always_comb begin
		sel = '0;
		any_ready = 1'b0;
		for (int i = n_entry - 1; i >= 0; i--) begin
			if (e[i].valid && e[i].opd.ready) begin
				sel = idx_w'(i);
				any_ready = 1'b1;
			end
		end
	end

	assign dispatch.valid = any_ready;
	assign dispatch.tag = e[sel].tag;
	assign dispatch.data = e[sel].opd.data;

	assign fire = any_ready && dispatch.ready;
	assign issue.ready = !e[n_entry-1].valid || fire;  // Last slot frees up on dispatch
	assign accept = issue.valid && issue.ready;

	always_comb begin
		n_valid = '0;
		for (int i = 0; i < n_entry; i++) begin
			n_valid = n_valid + cnt_w'(e[i].valid);
		end
	end

	assign n_keep = n_valid - cnt_w'(fire);

	// ----------------------------------------------------------
	// Compaction and insert
	// ----------------------------------------------------------
	always_comb begin
		int src;
		for (int i = 0; i < n_entry; i++) begin
			src = (fire && i >= int'(sel)) ? i + 1 : i;  // Skip the dispatched slot
			if (i < int'(n_keep)) begin
				e_next[i] = e_upd[src];
			end else if (i == int'(n_keep) && accept) begin
				e_next[i] = e_new;
			end else begin
				e_next[i] = e[i];
				e_next[i].valid = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < n_entry; i++) begin
			if (reset)
				e[i].valid <= 1'b0;
			else
				e[i] <= e_next[i];
		end
	end
endmodule

// File: design/itof_convert.sv
`timescale 1ns/10ps

module itof_convert
	import ooo_types_pkg::*;
	import fp_format_pkg::*;
(
	input logic clk,
	input logic reset,
	itof_dispatch_if.converter dispatch,
	output logic result_valid,
	output tag_t result_tag,
	output logic [31:0] result_data,
	input logic result_ready
);
	logic adv;

	// Stage 1
	logic s1_valid;
	tag_t s1_tag;
	logic s1_sign;
	logic [31:0] s1_mag;

	// Stage 2
	logic s2_valid;
	tag_t s2_tag;
	logic s2_sign;
	logic s2_zero;
	logic [7:0] s2_exp;
	logic [22:0] s2_man;
	logic s2_guard;
	logic s2_sticky;

	logic [5:0] lz;
	logic [31:0] norm;
	logic [7:0] exp_n;
	logic round_up;
	logic [23:0] man_r;
	logic [7:0] exp_r;
	fp32_word_u res_word;

	// Whole pipe moves or holds together
	assign adv = !result_valid || result_ready;
	assign dispatch.ready = adv;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			result_valid <= 1'b0;
		end else if (adv) begin
			s1_valid <= dispatch.valid;
			s2_valid <= s1_valid;
			result_valid <= s2_valid;
		end
	end

	// ----------------------------------------------------------
	// Stage 1 takes sign and magnitude
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (adv) begin
			s1_tag <= dispatch.tag;
			s1_sign <= dispatch.data[31];
			// -2^31 wraps to 32'h8000_0000 which reads unsigned as 2^31
			s1_mag <= dispatch.data[31] ? -dispatch.data : dispatch.data;
		end
	end

	// ----------------------------------------------------------
	// Stage 2 normalizes
	// ----------------------------------------------------------
	always_comb begin
		lz = 6'd32;
		for (int i = 0; i < 32; i++) begin
			if (s1_mag[i])
				lz = 6'(31 - i);  // Highest set bit wins
		end
	end

	assign norm = s1_mag << lz;  // Leading one lands in bit 31
	assign exp_n = 8'(fp32_exp_bias + 31) - {2'b00, lz};

	always_ff @(posedge clk) begin
		if (adv) begin
			s2_tag <= s1_tag;
			s2_sign <= s1_sign;
			s2_zero <= (s1_mag == '0);
			s2_exp <= exp_n;
			s2_man <= norm[30:8];
			s2_guard <= norm[7];
			s2_sticky <= |norm[6:0];
		end
	end

	// ----------------------------------------------------------
	// Stage 3 rounds to nearest even and packs
	// ----------------------------------------------------------
	assign round_up = s2_guard && (s2_sticky || s2_man[0]);
	assign man_r = {1'b0, s2_man} + 24'(round_up);
	assign exp_r = s2_exp + 8'(man_r[23]);  // Carry out bumps the exponent and leaves mantissa 0

	always_ff @(posedge clk) begin
		if (adv) begin
			result_tag <= s2_tag;
			if (s2_zero) begin
				res_word.fields.sign <= 1'b0;
				res_word.fields.exponent <= 8'd0;
				res_word.fields.mantissa <= 23'd0;
			end else begin
				res_word.fields.sign <= s2_sign;
				res_word.fields.exponent <= exp_r;
				res_word.fields.mantissa <= man_r[22:0];
			end
		end
	end

	assign result_data = res_word.raw;
endmodule

// File: design/itof_unit.sv
`timescale 1ns/10ps

module itof_unit
	import ooo_types_pkg::*;
#(
	parameter int n_entry = 2
) (
	input logic clk,
	input logic reset,

	input logic issue_valid,
	output logic issue_ready,
	input tag_t issue_tag,
	input logic issue_opd_ready,
	input tag_t issue_opd_tag,
	input logic [31:0] issue_opd_data,

	input logic gpr_cdb_valid,
	input tag_t gpr_cdb_tag,
	input logic [31:0] gpr_cdb_data,

	output logic result_valid,
	input logic result_ready,
	output tag_t result_tag,
	output logic [31:0] result_data
);
	cdb_t gpr_cdb;

	itof_issue_if issue_bus ();
	itof_dispatch_if disp_bus ();

	// ----------------------------------------------------------
	// Port packing
	// ----------------------------------------------------------
	assign issue_bus.valid = issue_valid;
	assign issue_bus.tag = issue_tag;
	assign issue_bus.operand.ready = issue_opd_ready;
	assign issue_bus.operand.tag = issue_opd_tag;
	assign issue_bus.operand.data = issue_opd_data;
	assign issue_ready = issue_bus.ready;

	assign gpr_cdb.valid = gpr_cdb_valid;
	assign gpr_cdb.tag = gpr_cdb_tag;
	assign gpr_cdb.data = gpr_cdb_data;

	// ----------------------------------------------------------
	// Station and converter
	// ----------------------------------------------------------
	itof_station #(
		.n_entry(n_entry)
	) u_station (
		.clk(clk),
		.reset(reset),
		.issue(issue_bus),
		.gpr_cdb(gpr_cdb),
		.dispatch(disp_bus)
	);

	itof_convert u_convert (
		.clk(clk),
		.reset(reset),
		.dispatch(disp_bus),
		.result_valid(result_valid),
		.result_tag(result_tag),
		.result_data(result_data),
		.result_ready(result_ready)
	);
endmodule

// File: testbench/itof_unit_tb.sv
`timescale 1ns/10ps

module itof_unit_tb
	import ooo_types_pkg::*;
();
	localparam int n_entry = 2;
	localparam int max_cases = 64;
	localparam int n_tags = 1 << tag_width;

	logic clk = 1'b0;
	logic reset;
	logic issue_valid;
	logic issue_ready;
	tag_t issue_tag;
	logic issue_opd_ready;
	tag_t issue_opd_tag;
	logic [31:0] issue_opd_data;
	logic gpr_cdb_valid;
	tag_t gpr_cdb_tag;
	logic [31:0] gpr_cdb_data;
	logic result_valid;
	logic result_ready;
	tag_t result_tag;
	logic [31:0] result_data;

	// Case table from the data file
	string case_name[max_cases];
	logic [31:0] case_opd[max_cases];
	tag_t case_tag[max_cases];
	bit case_wait[max_cases];
	int case_delay[max_cases];
	logic [31:0] case_exp[max_cases];
	int n_cases;

	// Shared scoreboard state
	bit inflight[n_tags];
	int tag_case[n_tags];
	bit waiting_mask[n_tags];  // Producer tags still owed a broadcast
	bit bc_sent[max_cases];
	int n_accepted;
	int n_done;
	int max_done;
	bit hold_pending;
	tag_t held_tag;
	logic [31:0] held_data;
	bit after_reset;
	bit stall_seen;
	bit hold_seen;
	bit ooo_seen;
	bit decoy_seen;
	int cycle_count;
	int cycle_limit;
	integer seed;

	itof_unit #(
		.n_entry(n_entry)
	) dut (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready),
		.issue_tag(issue_tag),
		.issue_opd_ready(issue_opd_ready),
		.issue_opd_tag(issue_opd_tag),
		.issue_opd_data(issue_opd_data),
		.gpr_cdb_valid(gpr_cdb_valid),
		.gpr_cdb_tag(gpr_cdb_tag),
		.gpr_cdb_data(gpr_cdb_data),
		.result_valid(result_valid),
		.result_ready(result_ready),
		.result_tag(result_tag),
		.result_data(result_data)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	task automatic stop_run(string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic report_mismatch(string test, logic [31:0] expected, logic [31:0] actual);
		stop_run($sformatf("CHECK FAILED %s expected %h actual %h", test, expected, actual));
	endtask

	// Producer of a waiting case is its dest tag with the top bit flipped
	function automatic tag_t producer_of(tag_t t);
		return t ^ (tag_t'(1) << (tag_width - 1));
	endfunction

	task automatic load_cases();
		int fd;
		int n;
		string line;
		string name;
		logic [31:0] opd;
		logic [31:0] tag_v;
		int w;
		int d;
		logic [31:0] exp_v;
		fd = $fopen("testbench/itof_cases.txt", "r");
		if (fd == 0) begin
			stop_run("Could not open the case file testbench/itof_cases.txt");
		end else begin
			while (!$feof(fd) && n_cases < max_cases) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != "#") begin  // Skip comments and blanks
					n = $sscanf(line, "%s %h %h %d %d %h", name, opd, tag_v, w, d, exp_v);
					if (n == 6) begin
						case_name[n_cases] = name;
						case_opd[n_cases] = opd;
						case_tag[n_cases] = tag_t'(tag_v);
						case_wait[n_cases] = (w != 0);
						case_delay[n_cases] = d;
						case_exp[n_cases] = exp_v;
						n_cases++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// ----------------------------------------------------------
	// Stimulus for issue, broadcasts and result_ready
	// ----------------------------------------------------------
	initial begin
		bit accepted;
		bit cur_bc;
		int cur;
		int next_case;
		int drv_cycle;
		int a;
		int pick;
		int k;
		logic [31:0] rnd;
		tag_t dtag;
		int bc_due[$];
		int bc_case[$];

		reset = 1'b1;
		issue_valid = 1'b0;
		issue_tag = '0;
		issue_opd_ready = 1'b0;
		issue_opd_tag = '0;
		issue_opd_data = '0;
		gpr_cdb_valid = 1'b0;
		gpr_cdb_tag = '0;
		gpr_cdb_data = '0;
		result_ready = 1'b0;
		seed = 32'hbd706a1b;
		max_done = -1;
		cur = -1;
		cur_bc = 1'b0;
		next_case = 0;
		drv_cycle = 0;
		load_cases();
		cycle_limit = 20 * n_cases + 100;

		repeat (8) @(posedge clk);
		reset <= 1'b0;

		while (n_done < n_cases) begin
			@(negedge clk);
			accepted = (cur >= 0) && issue_ready;
			@(posedge clk);
			a = drv_cycle;  // Cycle that just ended
			drv_cycle++;
			if (accepted) begin
				n_accepted++;
				if (case_wait[cur]) begin
					if (case_delay[cur] == 0 && cur_bc) begin
						bc_sent[cur] = 1'b1;
						waiting_mask[producer_of(case_tag[cur])] = 1'b0;
					end else begin
						bc_due.push_back(a + case_delay[cur]);
						bc_case.push_back(cur);
					end
				end
				cur = -1;
			end

			// Next case once its tag is free again
			if (cur < 0 && next_case < n_cases && !inflight[case_tag[next_case]]) begin
				cur = next_case;
				next_case++;
				inflight[case_tag[cur]] = 1'b1;
				tag_case[case_tag[cur]] = cur;
				bc_sent[cur] = !case_wait[cur];
				if (case_wait[cur])
					waiting_mask[producer_of(case_tag[cur])] = 1'b1;
			end

			if (cur >= 0) begin
				issue_valid <= 1'b1;
				issue_tag <= case_tag[cur];
				issue_opd_ready <= !case_wait[cur];
				issue_opd_tag <= case_wait[cur] ? producer_of(case_tag[cur]) : '0;
				issue_opd_data <= case_wait[cur] ? ~case_opd[cur] : case_opd[cur];  // Stale data
			end else begin
				issue_valid <= 1'b0;
			end

			// Scheduled broadcasts first, then same-cycle, then a decoy
			cur_bc = 1'b0;
			pick = -1;
			for (int j = 0; j < bc_due.size(); j++) begin
				if (pick < 0 && bc_due[j] <= drv_cycle)
					pick = j;
			end
			rnd = $random(seed);
			if (pick >= 0) begin
				k = bc_case[pick];
				gpr_cdb_valid <= 1'b1;
				gpr_cdb_tag <= producer_of(case_tag[k]);
				gpr_cdb_data <= case_opd[k];
				bc_sent[k] = 1'b1;
				waiting_mask[producer_of(case_tag[k])] = 1'b0;
				bc_due.delete(pick);
				bc_case.delete(pick);
			end else if (cur >= 0 && case_wait[cur] && case_delay[cur] == 0) begin
				gpr_cdb_valid <= 1'b1;
				gpr_cdb_tag <= producer_of(case_tag[cur]);
				gpr_cdb_data <= case_opd[cur];
				cur_bc = 1'b1;
			end else begin
				dtag = tag_t'(rnd >> 4);
				if (rnd[3:2] == 2'b00 && !waiting_mask[dtag]) begin
					gpr_cdb_valid <= 1'b1;  // Nobody waits on this tag
					gpr_cdb_tag <= dtag;
					gpr_cdb_data <= $random(seed);
					if (bc_due.size() > 0)
						decoy_seen = 1'b1;  // An accepted convert still waits
				end else begin
					gpr_cdb_valid <= 1'b0;
				end
			end
			result_ready <= rnd[0];
		end

		@(posedge clk);
		assert (!result_valid) else stop_run("result_valid still high after the last result");
		assert (ooo_seen) else stop_run("No result ever completed ahead of an older case");
		assert (stall_seen) else stop_run("issue_ready never fell with a convert waiting");
		assert (hold_seen) else stop_run("result_ready was never low under a valid result");
		assert (decoy_seen)
			else stop_run("No broadcast with a non-matching tag came while a convert waited");
		$display("Finished with no errors");
		$finish;
	end

	// ----------------------------------------------------------
	// Result monitor sampled mid-cycle
	// ----------------------------------------------------------
	always @(negedge clk) begin
		int k;
		if (reset) begin
			assert (!result_valid && issue_ready)
				else stop_run("During reset result_valid is high or issue_ready is low");
			after_reset = 1'b1;
		end else begin
			if (after_reset) begin
				assert (!result_valid && issue_ready)
					else stop_run("Right after reset result_valid is high or issue_ready is low");
				after_reset = 1'b0;
			end
			if (issue_valid && !issue_ready) begin
				stall_seen = 1'b1;
				assert (n_accepted - n_done >= n_entry)
					else stop_run("issue_ready fell with a free entry in the station");
			end
			if (hold_pending) begin
				assert (result_valid) else stop_run("result_valid dropped before result_ready");
				assert (result_tag == held_tag)
					else report_mismatch("held result tag", 32'(held_tag), 32'(result_tag));
				assert (result_data == held_data)
					else report_mismatch("held result data", held_data, result_data);
			end
			hold_pending = result_valid && !result_ready;
			if (hold_pending) begin
				held_tag = result_tag;
				held_data = result_data;
				hold_seen = 1'b1;
			end
			if (result_valid && result_ready) begin
				assert (inflight[result_tag])
					else stop_run($sformatf("Result with tag %h that is not in flight", result_tag));
				k = tag_case[result_tag];
				assert (bc_sent[k])
					else stop_run($sformatf("Case %s finished before its broadcast", case_name[k]));
				assert (result_data == case_exp[k])
					else report_mismatch(case_name[k], case_exp[k], result_data);
				inflight[result_tag] = 1'b0;
				n_done++;
				if (k < max_done)
					ooo_seen = 1'b1;
				else
					max_done = k;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit)
			stop_run($sformatf("Timeout after %0d cycles with results still missing", cycle_limit));
	end
endmodule

// File: ooo_itof.f
design/ooo_types_pkg.sv
design/fp_format_pkg.sv
design/itof_issue_if.sv
design/itof_dispatch_if.sv
design/itof_station.sv
design/itof_convert.sv
design/itof_unit.sv
testbench/itof_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the integer-to-float unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module itof_unit_tb \
	-f ooo_itof.f \
	-o itof_sim

./obj_dir/itof_sim | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
	echo "Simulation PASSED"
else
	echo "Simulation FAILED"
	exit 1
fi

// File: testbench/itof_cases.txt
# name operand_hex dest_tag_hex wait delay expected_fp32_hex
# wait 1 issues the operand not ready; its broadcast comes delay cycles after issue
zero 00000000 0 0 0 00000000
one 00000001 1 0 0 3f800000
minus_one ffffffff 2 0 0 bf800000
two 00000002 3 0 0 40000000
three 00000003 4 0 0 40400000
seven 00000007 5 0 0 40e00000
ten 0000000a 6 0 0 41200000
minus_ten fffffff6 7 0 0 c1200000
hundred 00000064 8 0 0 42c80000
minus_hundred ffffff9c 9 0 0 c2c80000
thousand 000003e8 a 0 0 447a0000
pos_12345 00003039 b 0 0 4640e400
neg_12345 ffffcfc7 c 0 0 c640e400
pow2_10 00000400 d 0 0 44800000
pow2_16 00010000 e 0 0 47800000
pow2_24 01000000 f 0 0 4b800000
pow2_30 40000000 0 0 0 4e800000
wait_late 00000007 1 1 12 40e00000
young_ready 00010000 2 0 0 47800000
tie_even_lo 01000001 3 0 0 4b800000
tie_even_hi 01000003 4 0 0 4b800002
exact_2p24_2 01000002 5 0 0 4b800001
tie_down_even 01000005 6 0 0 4b800002
tie_up_even 01000007 7 0 0 4b800004
below_half 02000001 8 0 0 4c000000
above_half 02000003 9 0 0 4c000001
max_int 7fffffff a 0 0 4f000000
min_int 80000000 b 0 0 cf000000
max_exact 7fffff80 c 0 0 4effffff
carry_round 7fffffc0 d 0 0 4f000000
all_ones_24 00ffffff e 0 0 4b7fffff
neg_2p24_1 feffffff f 0 0 cb800000
wake_same 00000003 0 1 0 40400000
wake_next fffffff6 1 1 1 c1200000
wake_mid 00003039 2 1 3 4640e400
ready_after 00000001 3 0 0 3f800000
wake_pair_a 7fffffff 4 1 5 4f000000
wake_pair_b 80000000 5 1 2 cf000000
wake_zero 00000000 6 1 4 00000000
ready_last ffffffff 7 0 0 bf800000
